// File: hdl/nrz_2of7_decoder.sv
// --------------------------------------------------
// NRZ 2-of-7 decoder
// last accepted wire state, ack toggle, and
// classification of the current wire change
// --------------------------------------------------
`timescale 1ns/1ps
module nrz_2of7_decoder
(
  input  logic                  CLK_IN,
  input  logic                  RESET_IN,
  input  spinn_rx_pkg::link_t   SL_DATA_2OF7_IN,
  input  logic                  accept_sym,  // consume current change
  input  logic                  restart,     // resync to the wires
  output logic                  SL_ACK_OUT,
  output logic                  new_sym,     // any complete change
  output logic                  data_sym,
  output logic                  eop_sym,
  output logic                  oob_sym,
  output spinn_rx_pkg::symbol_t symbol
);

  spinn_rx_pkg::link_t last_wires;  // wires at last ack
  spinn_rx_pkg::link_t diff;        // wires changed since
  logic                incomplete;

  // --------------------------------------------------
  // wire state and ack
  // --------------------------------------------------
  always_ff @(posedge CLK_IN or posedge RESET_IN)
    if (RESET_IN)
    begin
      last_wires <= '0;
      SL_ACK_OUT <= 1'b0;
    end
    else if (restart)
    begin
      last_wires <= SL_DATA_2OF7_IN;
      SL_ACK_OUT <= 1'b1;  // link idles with ack high
    end
    else if (accept_sym)
    begin
      last_wires <= SL_DATA_2OF7_IN;
      SL_ACK_OUT <= ~SL_ACK_OUT;  // NRZ ack
    end

  assign diff = SL_DATA_2OF7_IN ^ last_wires;

  // --------------------------------------------------
  // classification
  // --------------------------------------------------
  always_comb
  begin
    symbol   = '0;
    data_sym = 1'b1;
    case (diff)
      7'b0010001: symbol = 4'd0;
      7'b0010010: symbol = 4'd1;
      7'b0010100: symbol = 4'd2;
      7'b0011000: symbol = 4'd3;
      7'b0100001: symbol = 4'd4;
      7'b0100010: symbol = 4'd5;
      7'b0100100: symbol = 4'd6;
      7'b0101000: symbol = 4'd7;
      7'b1000001: symbol = 4'd8;
      7'b1000010: symbol = 4'd9;
      7'b1000100: symbol = 4'd10;
      7'b1001000: symbol = 4'd11;
      7'b0000011: symbol = 4'd12;
      7'b0000110: symbol = 4'd13;
      7'b0001100: symbol = 4'd14;
      7'b0001001: symbol = 4'd15;
      default:    data_sym = 1'b0;  // not a data code
    endcase
  end

  assign eop_sym    = (diff == spinn_rx_pkg::EOP_CODE);
  assign incomplete = ($countones(diff) <= 1);  // still waiting for 2nd wire
  assign oob_sym    = !data_sym && !eop_sym && !incomplete;
  assign new_sym    = data_sym || eop_sym || oob_sym;

endmodule

// File: hdl/packet_assembler.sv
// --------------------------------------------------
// packet assembler
// symbol shift buffer and short/long formatting
// --------------------------------------------------
`timescale 1ns/1ps
module packet_assembler
(
  input  logic                  CLK_IN,
  input  logic                  RESET_IN,
  input  logic                  shift_en,
  input  spinn_rx_pkg::symbol_t symbol,
  input  logic                  long_pkt,
  output spinn_rx_pkg::pkt_t    pkt_data
);

  localparam int PAD_BITS = spinn_rx_pkg::PKT_BITS - spinn_rx_pkg::SHORT_BITS;

  spinn_rx_pkg::pkt_t pkt_buf;

  // --------------------------------------------------
  // shift in at the top, first symbol drifts lowest
  // --------------------------------------------------
  always_ff @(posedge CLK_IN or posedge RESET_IN)
    if (RESET_IN)
      pkt_buf <= '0;
    else if (shift_en)
      pkt_buf <= {symbol, pkt_buf[spinn_rx_pkg::PKT_BITS-1:spinn_rx_pkg::SYM_BITS]};

  // short packet only filled the top 40 bits
  always_comb
    if (long_pkt)
      pkt_data = pkt_buf;
    else
      pkt_data = {{PAD_BITS{1'b0}},
                  pkt_buf[spinn_rx_pkg::PKT_BITS-1 -: spinn_rx_pkg::SHORT_BITS]};

endmodule

// File: hdl/packet_out_reg.sv
// --------------------------------------------------
// output packet register
// one-entry holding register with valid/ready,
// busy status and packet count pulse
// --------------------------------------------------
`timescale 1ns/1ps
module packet_out_reg
(
  input  logic               CLK_IN,
  input  logic               RESET_IN,
  input  logic               pkt_load,
  input  spinn_rx_pkg::pkt_t pkt_data,
  input  logic               PKT_RDY_IN,
  output spinn_rx_pkg::pkt_t PKT_DATA_OUT,
  output logic               PKT_VLD_OUT,
  output logic               busy,
  output logic               COUNT_PACKET_OUT
);

  logic full;

  // --------------------------------------------------
  // payload, only moves on load
  // --------------------------------------------------
  always_ff @(posedge CLK_IN)
    if (pkt_load)
      PKT_DATA_OUT <= pkt_data;

  // --------------------------------------------------
  // occupancy
  // --------------------------------------------------
  always_ff @(posedge CLK_IN or posedge RESET_IN)
    if (RESET_IN)
      full <= 1'b0;
    else if (pkt_load)
      full <= 1'b1;  // load wins over drain
    else if (PKT_RDY_IN)
      full <= 1'b0;

  assign PKT_VLD_OUT = full;
  assign busy        = full && !PKT_RDY_IN;  // drains this edge if ready

  // one pulse per delivered packet
  always_ff @(posedge CLK_IN or posedge RESET_IN)
    if (RESET_IN)
      COUNT_PACKET_OUT <= 1'b0;
    else
      COUNT_PACKET_OUT <= PKT_VLD_OUT && PKT_RDY_IN;

endmodule

// File: hdl/rx_frame_fsm.sv
// --------------------------------------------------
// receiver frame FSM
// steers symbol acceptance, counting, shifting and
// packet hand-off to the output register
// --------------------------------------------------
`timescale 1ns/1ps
module rx_frame_fsm
(
  input  logic CLK_IN,
  input  logic RESET_IN,
  input  logic new_sym,
  input  logic data_sym,
  input  logic eop_sym,
  input  logic oob_sym,
  input  logic exp_eop,      // count says EOP is due
  input  logic busy,         // output register can't take a packet
  output logic accept_sym,
  output logic count_clear,
  output logic count_step,
  output logic first_sym,    // first data symbol of a packet
  output logic shift_en,
  output logic pkt_load,
  output logic restart
);

  spinn_rx_pkg::rx_state_t state;
  spinn_rx_pkg::rx_state_t state_nxt;
  logic                    in_idle;
  logic                    in_tran;
  logic                    good_eop;  // eop at the right count
  logic                    stall;     // good eop but nowhere to put it

  assign in_idle  = (state == spinn_rx_pkg::IDLE);
  assign in_tran  = (state == spinn_rx_pkg::TRAN);
  assign good_eop = in_tran && eop_sym && exp_eop;
  assign stall    = good_eop && busy;

  // --------------------------------------------------
  // state register and next state
  // --------------------------------------------------
  always_ff @(posedge CLK_IN or posedge RESET_IN)
    if (RESET_IN)
      state <= spinn_rx_pkg::REST;
    else
      state <= state_nxt;

  always_comb
  begin
    state_nxt = state;
    case (state)
      spinn_rx_pkg::REST: state_nxt = spinn_rx_pkg::IDLE;
      spinn_rx_pkg::IDLE:
        if (data_sym)
          state_nxt = spinn_rx_pkg::TRAN;  // packet starts
        else if (oob_sym)
          state_nxt = spinn_rx_pkg::ERR;
      spinn_rx_pkg::TRAN:
        if (oob_sym)
          state_nxt = spinn_rx_pkg::ERR;   // drop packet
        else if (eop_sym && !stall)
          state_nxt = spinn_rx_pkg::IDLE;  // sent, or bad count dropped
      spinn_rx_pkg::ERR:
        if (eop_sym)
          state_nxt = spinn_rx_pkg::IDLE;
      default: state_nxt = spinn_rx_pkg::REST;
    endcase
  end

  // --------------------------------------------------
  // control outputs
  // --------------------------------------------------
  assign restart     = (state == spinn_rx_pkg::REST);
  assign accept_sym  = new_sym && !restart && !stall;  // hold ack while stalled
  assign count_step  = data_sym && (in_idle || in_tran);
  assign first_sym   = data_sym && in_idle;
  assign count_clear = !count_step && !in_tran;  // idle, rest, err
  assign shift_en    = count_step;
  assign pkt_load    = good_eop && !busy;

endmodule

// File: hdl/spinn_link_rx.sv
// --------------------------------------------------
// link receiver top level
// decoder, frame FSM, counter, assembler, output reg
// --------------------------------------------------
`timescale 1ns/1ps
module spinn_link_rx
(
  input  logic                CLK_IN,
  input  logic                RESET_IN,
  input  spinn_rx_pkg::link_t SL_DATA_2OF7_IN,
  output logic                SL_ACK_OUT,
  output spinn_rx_pkg::pkt_t  PKT_DATA_OUT,
  output logic                PKT_VLD_OUT,
  input  logic                PKT_RDY_IN,
  output logic                COUNT_PACKET_OUT
);

  logic                  new_sym;
  logic                  data_sym;
  logic                  eop_sym;
  logic                  oob_sym;
  spinn_rx_pkg::symbol_t symbol;
  logic                  accept_sym;
  logic                  restart;
  logic                  count_clear;
  logic                  count_step;
  logic                  first_sym;
  logic                  shift_en;
  logic                  pkt_load;
  logic                  exp_eop;
  logic                  long_pkt;
  logic                  busy;
  spinn_rx_pkg::pkt_t    pkt_data;

  nrz_2of7_decoder i_decoder (
    .CLK_IN, .RESET_IN, .SL_DATA_2OF7_IN, .accept_sym, .restart, .SL_ACK_OUT,
    .new_sym, .data_sym, .eop_sym, .oob_sym, .symbol
  );

  rx_frame_fsm i_fsm (
    .CLK_IN, .RESET_IN, .new_sym, .data_sym, .eop_sym, .oob_sym, .exp_eop, .busy,
    .accept_sym, .count_clear, .count_step, .first_sym, .shift_en, .pkt_load,
    .restart
  );

  symbol_counter i_counter (
    .CLK_IN, .RESET_IN, .count_clear, .count_step, .first_sym, .symbol,
    .exp_eop, .long_pkt
  );

  packet_assembler i_assembler (
    .CLK_IN, .RESET_IN, .shift_en, .symbol, .long_pkt, .pkt_data
  );

  packet_out_reg i_out_reg (
    .CLK_IN, .RESET_IN, .pkt_load, .pkt_data, .PKT_RDY_IN, .PKT_DATA_OUT,
    .PKT_VLD_OUT, .busy, .COUNT_PACKET_OUT
  );

endmodule

// File: hdl/spinn_rx_pkg.sv
// --------------------------------------------------
// link receiver shared constants and types
// packet sizes, EOP code, wire, symbol, packet and
// state types
// --------------------------------------------------
package spinn_rx_pkg;

  // --------------------------------------------------
  // packet geometry, fixed by the link protocol
  // --------------------------------------------------
  localparam int PKT_BITS   = 72;  // long packet
  localparam int SHORT_BITS = 40;  // short packet
  localparam int SYM_BITS   = 4;   // data bits per symbol
  localparam int SHORT_SYMS = 10;  // SHORT_BITS / SYM_BITS
  localparam int LONG_SYMS  = 18;  // PKT_BITS / SYM_BITS

  // --------------------------------------------------
  // types
  // --------------------------------------------------
  typedef logic [6:0]            link_t;     // 2-of-7 wires
  typedef logic [SYM_BITS-1:0]   symbol_t;
  typedef logic [PKT_BITS-1:0]   pkt_t;
  typedef logic [4:0]            sym_cnt_t;  // up to LONG_SYMS

  // end-of-packet, wires 5 and 6 change
  localparam link_t EOP_CODE = 7'b1100000;

  // receiver control states
  typedef enum logic [1:0] {
    REST = 2'd0,  // one cycle after reset, grabs the wires
    IDLE = 2'd1,  // waiting for first symbol
    TRAN = 2'd2,  // packet in progress
    ERR  = 2'd3   // dropping until next EOP
  } rx_state_t;

endpackage

// File: hdl/symbol_counter.sv
// --------------------------------------------------
// symbol counter
// data symbols per packet, latched packet size and
// expected-EOP flag
// --------------------------------------------------
`timescale 1ns/1ps
module symbol_counter
(
  input  logic                  CLK_IN,
  input  logic                  RESET_IN,
  input  logic                  count_clear,
  input  logic                  count_step,
  input  logic                  first_sym,
  input  spinn_rx_pkg::symbol_t symbol,
  output logic                  exp_eop,
  output logic                  long_pkt
);

  spinn_rx_pkg::sym_cnt_t cnt;

  always_ff @(posedge CLK_IN or posedge RESET_IN)
    if (RESET_IN)
    begin
      cnt      <= '0;
      long_pkt <= 1'b0;
    end
    else if (count_clear)
      cnt <= '0;
    else if (count_step)
    begin
      if (first_sym)
      begin
        cnt      <= spinn_rx_pkg::sym_cnt_t'(1);  // restart at first symbol
        long_pkt <= symbol[1];                    // size bit
      end
      else
        cnt <= cnt + 1'b1;
    end

  // short packets end at 10, anything ends at 18
  assign exp_eop = (!long_pkt && (cnt == spinn_rx_pkg::SHORT_SYMS))
                || (cnt == spinn_rx_pkg::LONG_SYMS);

endmodule

// File: run.sh
#!/bin/sh
# build the link receiver testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_spinn_link_rx -f vlog.f -o sim_tb
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation did not run to completion"
  exit 1
fi

if printf '%s\n' "$out" | grep -q "^TESTS PASSED$"; then
  exit 0
fi
exit 1

// File: verification/tb_spinn_link_rx.sv
// --------------------------------------------------
// link receiver testbench
// 2-of-7 link driver, packet model, monitor,
// compare tasks and cycle timeout
// --------------------------------------------------
`timescale 1ns/1ps
module tb_spinn_link_rx;

  localparam int N_SHORT  = 8;
  localparam int N_LONG   = 6;
  localparam int N_MIX    = 10;
  localparam int N_ERR    = 4;   // bad frames, each chased by a good one
  localparam int N_OOB    = 4;
  localparam int N_BP     = 12;
  localparam int MAX_PKTS = N_SHORT + N_LONG + N_MIX + 2 * N_ERR + 3 * N_OOB + N_BP;
  localparam int STALL    = 40;  // worst cycles per symbol, gaps and long ready droughts
  localparam int LIMIT    = MAX_PKTS * 21 * STALL + 2000;  // 21 symbols max per frame

  logic                CLK_IN     = 1'b0;
  logic                RESET_IN;
  spinn_rx_pkg::link_t SL_DATA_2OF7_IN;
  logic                SL_ACK_OUT;
  spinn_rx_pkg::pkt_t  PKT_DATA_OUT;
  logic                PKT_VLD_OUT;
  logic                PKT_RDY_IN = 1'b1;
  logic                COUNT_PACKET_OUT;

  logic [31:0]         seed       = 32'h669c;  // main stimulus stream
  logic [31:0]         rdy_seed   = 32'h669c;  // ready stream
  logic                bp_on      = 1'b0;
  spinn_rx_pkg::link_t wires;                  // present wire levels
  spinn_rx_pkg::pkt_t  exp_q[$];               // expected packets, in order
  string               cur_test;
  int                  syms_sent  = 0;
  int                  n_got      = 0;         // monitor side
  int                  pulses     = 0;
  int                  ack_toggles = 0;
  logic                ack_prev   = 1'b0;
  int                  checks     = 0;
  int                  errors     = 0;
  int                  mon_checks = 0;
  int                  mon_errors = 0;
  int                  err_base;
  int                  n_tests    = 0;
  int                  ack_base;
  int                  sent_base;

  always #4 CLK_IN = ~CLK_IN;  // 8 ns period

  spinn_link_rx i_spinn_link_rx (
    .CLK_IN, .RESET_IN, .SL_DATA_2OF7_IN, .SL_ACK_OUT, .PKT_DATA_OUT,
    .PKT_VLD_OUT, .PKT_RDY_IN, .COUNT_PACKET_OUT
  );

  // --------------------------------------------------
  // random numbers, 32-bit Fibonacci LFSR
  // --------------------------------------------------
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // taps 32 22 2 1
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      seed = lfsr_next(seed);
      v    = {v[30:0], seed[0]};  // one step per bit
    end
    return v;
  endfunction

  // 2-of-7 code table, data values 0..15
  function automatic spinn_rx_pkg::link_t code_of(input spinn_rx_pkg::symbol_t s);
    case (s)
      4'd0:    return 7'b0010001;
      4'd1:    return 7'b0010010;
      4'd2:    return 7'b0010100;
      4'd3:    return 7'b0011000;
      4'd4:    return 7'b0100001;
      4'd5:    return 7'b0100010;
      4'd6:    return 7'b0100100;
      4'd7:    return 7'b0101000;
      4'd8:    return 7'b1000001;
      4'd9:    return 7'b1000010;
      4'd10:   return 7'b1000100;
      4'd11:   return 7'b1001000;
      4'd12:   return 7'b0000011;
      4'd13:   return 7'b0000110;
      4'd14:   return 7'b0001100;
      default: return 7'b0001001;
    endcase
  endfunction

  // --------------------------------------------------
  // compare tasks
  // --------------------------------------------------
  task automatic check_pkt(input string name, input spinn_rx_pkg::pkt_t exp,
                           input spinn_rx_pkg::pkt_t act);
    mon_checks++;  // only called from the monitor
    if (exp !== act)
    begin
      mon_errors++;
      $display("Mismatch %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    checks++;
    if (exp != act)
    begin
      errors++;
      $display("Mismatch %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    checks++;
    if (exp !== act)
    begin
      errors++;
      $display("Mismatch %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  // --------------------------------------------------
  // link driver
  // --------------------------------------------------
  task automatic send_code(input spinn_rx_pkg::link_t code);
    logic                ack0;
    spinn_rx_pkg::link_t lo;
    spinn_rx_pkg::link_t target;
    int                  gap;
    ack0   = SL_ACK_OUT;
    lo     = code & (~code + 7'd1);  // lowest changing wire
    target = wires ^ code;
    if ($countones(code) == 2 && rand_bits(1) != 0)
    begin
      gap             = 1 + int'(rand_bits(2));
      SL_DATA_2OF7_IN = wires ^ lo;  // first wire alone, incomplete
      repeat (gap) @(negedge CLK_IN);
    end
    wires           = target;
    SL_DATA_2OF7_IN = wires;
    @(negedge CLK_IN);
    while (SL_ACK_OUT == ack0)  // sender waits for the toggle
      @(negedge CLK_IN);
    syms_sent++;
  endtask

  // n data symbols then EOP, model queues only well-counted frames
  task automatic send_packet(input int n, input logic lng);
    spinn_rx_pkg::symbol_t s;
    spinn_rx_pkg::pkt_t    payload;
    payload = '0;
    for (int i = 0; i < n; i++)
    begin
      s = spinn_rx_pkg::symbol_t'(rand_bits(4));
      if (i == 0)
        s[1] = lng;  // size bit
      payload = payload | (spinn_rx_pkg::pkt_t'(s) << (4 * i));  // first lowest
      send_code(code_of(s));
    end
    if (n == (lng ? spinn_rx_pkg::LONG_SYMS : spinn_rx_pkg::SHORT_SYMS))
      exp_q.push_back(payload);
    send_code(spinn_rx_pkg::EOP_CODE);
  endtask

  task automatic send_rand_packet();
    logic lng;
    lng = (rand_bits(1) != 0);
    send_packet(lng ? spinn_rx_pkg::LONG_SYMS : spinn_rx_pkg::SHORT_SYMS, lng);
  endtask

  task automatic send_junk(input int n);
    for (int i = 0; i < n; i++)
      send_code(code_of(spinn_rx_pkg::symbol_t'(rand_bits(4))));
  endtask

  // --------------------------------------------------
  // test bookkeeping
  // --------------------------------------------------
  task automatic start_test(input string name);
    cur_test = name;
    err_base = errors + mon_errors;
  endtask

  task automatic wait_drain();
    while (n_got < exp_q.size())
      @(negedge CLK_IN);
    repeat (3) @(negedge CLK_IN);  // count pulse and last ack land
  endtask

  task automatic end_test();
    wait_drain();
    check_count({cur_test, " count"}, exp_q.size(), pulses);
    n_tests++;
    $display("%s: done, %0d errors", cur_test, errors + mon_errors - err_base);
  endtask

  // --------------------------------------------------
  // monitor, ready driver, timeout
  // --------------------------------------------------
  always @(posedge CLK_IN)
  begin
    if (COUNT_PACKET_OUT)
      pulses++;
    if (!RESET_IN && PKT_VLD_OUT && PKT_RDY_IN)  // transfer on this edge
    begin
      if (n_got < exp_q.size())
        check_pkt(cur_test, exp_q[n_got], PKT_DATA_OUT);
      else
      begin
        mon_errors++;
        $display("%s: a packet came out when none was expected", cur_test);
      end
      n_got++;
    end
    if (SL_ACK_OUT != ack_prev)
      ack_toggles++;
    ack_prev = SL_ACK_OUT;
  end

  always @(negedge CLK_IN)
    if (bp_on)
    begin
      for (int i = 0; i < 5; i++)
        rdy_seed = lfsr_next(rdy_seed);  // one step per bit
      PKT_RDY_IN <= (rdy_seed[4:0] == 5'h1f);  // ready one cycle in 32
    end
    else
      PKT_RDY_IN <= 1'b1;

  initial
  begin
    repeat (LIMIT) @(posedge CLK_IN);
    $display("timeout: run still busy after %0d cycles", LIMIT);
    $display("TESTS FAILED");
    $finish;
  end

  // --------------------------------------------------
  // test sequence
  // --------------------------------------------------
  initial
  begin
    RESET_IN        = 1'b1;
    wires           = '0;
    SL_DATA_2OF7_IN = '0;
    repeat (8) @(negedge CLK_IN);
    RESET_IN = 1'b0;

    start_test("reset");
    check_bit("reset valid", 1'b0, PKT_VLD_OUT);
    check_bit("reset count", 1'b0, COUNT_PACKET_OUT);
    repeat (2) @(negedge CLK_IN);
    check_bit("reset ack", 1'b1, SL_ACK_OUT);  // REST raises ack
    end_test();

    start_test("short packets");
    for (int i = 0; i < N_SHORT; i++)
      send_packet(spinn_rx_pkg::SHORT_SYMS, 1'b0);
    end_test();

    start_test("long packets");
    for (int i = 0; i < N_LONG; i++)
      send_packet(spinn_rx_pkg::LONG_SYMS, 1'b1);
    for (int i = 0; i < N_MIX; i++)
      send_rand_packet();  // back-to-back mixed sizes
    end_test();

    start_test("frame errors");
    send_packet(5, 1'b0);   // too short
    send_rand_packet();
    send_packet(12, 1'b0);  // short overrun
    send_rand_packet();
    send_packet(10, 1'b1);  // long flag, short count
    send_rand_packet();
    send_packet(20, 1'b1);  // long overrun
    send_rand_packet();
    end_test();

    start_test("out-of-band");
    for (int r = 0; r < N_OOB; r++)
    begin
      send_junk(r);  // partial frame, none when r is 0
      send_code((r % 2 == 1) ? 7'b1010000 : 7'b0000111);  // unused pair / three wires
      send_junk(spinn_rx_pkg::LONG_SYMS - r);  // would fill a frame unless ignored
      send_code(spinn_rx_pkg::EOP_CODE);
      send_rand_packet();
    end
    end_test();

    start_test("back-pressure");
    ack_base  = ack_toggles;
    sent_base = syms_sent;
    @(posedge CLK_IN);
    bp_on = 1'b1;
    @(negedge CLK_IN);
    for (int i = 0; i < N_BP; i++)
      send_rand_packet();
    @(posedge CLK_IN);
    bp_on = 1'b0;
    @(negedge CLK_IN);
    wait_drain();
    check_count("back-pressure acks", syms_sent - sent_base, ack_toggles - ack_base);
    end_test();

    $display("tests %0d, checks %0d, errors %0d", n_tests, checks + mon_checks,
             errors + mon_errors);
    if (errors + mon_errors == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

// File: vlog.f
hdl/spinn_rx_pkg.sv
hdl/nrz_2of7_decoder.sv
hdl/rx_frame_fsm.sv
hdl/symbol_counter.sv
hdl/packet_assembler.sv
hdl/packet_out_reg.sv
hdl/spinn_link_rx.sv
verification/tb_spinn_link_rx.sv
